/* include/hazard_settings.svh */
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// Instruction, immediate and memory address width
`define HAZ_DATA_W 16

// Eight architectural registers
`define HAZ_REG_W 3

// Stages tracked after decode: ID, EX, MEM and WB
`define HAZ_DEPTH 4

`define HAZ_LINK_REG 7 // Return address register for JAL/JALR

`endif

/* hw/hazardPkg.sv */
`include "hazard_settings.svh"

package hazardPkg;

    typedef logic [4:0]            opcode_t;
    typedef logic [`HAZ_REG_W-1:0] regIdx_t;

    localparam opcode_t OP_NOP  = 5'b00001; // Reads nothing, never stalls
    localparam opcode_t OP_JR   = 5'b00101;
    localparam opcode_t OP_JAL  = 5'b00110;
    localparam opcode_t OP_JALR = 5'b00111;

    // Pending register write of one in-flight instruction
    typedef struct packed {
        regIdx_t dest;
        logic    valid;
    } regEntry_t;

    // Pending memory access of one in-flight instruction
    typedef struct packed {
        logic [`HAZ_DATA_W-1:0] addr;
        logic                   en;
    } memEntry_t;

    // Bypass selects, MSB first as seen on the forwards port
    typedef struct packed {
        logic exToExRs;
        logic memToExRs;
        logic exToExRt;
        logic memToExRt;
        logic exToIdRs;   // JR/JALR target from EX
        logic memToIdRs;  // JR/JALR target from MEM
    } fwdVec_t;

    function automatic opcode_t opcodeOf(input logic [`HAZ_DATA_W-1:0] instr);
        return instr[15:11];
    endfunction

    function automatic regIdx_t rsOf(input logic [`HAZ_DATA_W-1:0] instr);
        return instr[10:8];
    endfunction

    function automatic regIdx_t rtOf(input logic [`HAZ_DATA_W-1:0] instr);
        return instr[7:5];
    endfunction

endpackage

/* hw/stageTrackIf.sv */
`timescale 1ns/1ps

// One tracker of in-flight entries, from decode to writeback
interface stageTrackIf #(
    parameter type T = logic
) (
    input logic clk  // Sampling clock for checks on the combinational side
);
    T     push;      // Entry of the instruction now entering decode
    logic flush;     // Squash the entry leaving ID
    T     idEntry;
    T     exEntry;
    T     memEntry;
    T     wbEntry;

    modport ctrl (
        input  clk,
        output push,
        output flush
    );

    modport pipe (
        input  push,
        input  flush,
        output idEntry,
        output exEntry,
        output memEntry,
        output wbEntry
    );

    modport observe (
        input clk,
        input idEntry,
        input exEntry,
        input memEntry,
        input wbEntry
    );

endinterface

/* hw/stagePipe.sv */
`timescale 1ns/1ps
`include "hazard_settings.svh"

module stagePipe #(
    parameter type T = logic
) (
    input logic       clk,
    input logic       arstN,
    stageTrackIf.pipe trk
);

    localparam T emptyEntry = '0;

    // Shift one stage per clock, WB entry falls off the end
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            trk.idEntry  <= emptyEntry;
            trk.exEntry  <= emptyEntry;
            trk.memEntry <= emptyEntry;
            trk.wbEntry  <= emptyEntry;
        end else begin
            trk.idEntry  <= trk.push;
            trk.exEntry  <= trk.flush ? emptyEntry : trk.idEntry; // Taken branch kills ID
            trk.memEntry <= trk.exEntry;
            trk.wbEntry  <= trk.memEntry;
        end
    end

    squashEmpty: assert property (
        @(posedge clk) disable iff (!arstN)
        trk.flush |=> (trk.exEntry == emptyEntry)
    ) else $error("stagePipe: EX entry survived a flush");

    // A push not squashed on its way reaches WB after the tracked depth
    depthCarry: assert property (
        @(posedge clk) disable iff (!arstN)
        ($past(arstN, `HAZ_DEPTH) && !$past(trk.flush, `HAZ_DEPTH - 1))
        |-> (trk.wbEntry == $past(trk.push, `HAZ_DEPTH))
    ) else $error("stagePipe: WB entry does not match the push it came from");

endmodule

/* hw/regHazardCheck.sv */
`timescale 1ns/1ps
`include "hazard_settings.svh"

module regHazardCheck (
    input  logic [`HAZ_DATA_W-1:0] instr,
    input  logic                   branchTaken,
    stageTrackIf.observe           regTrk,
    stageTrackIf.observe           memTrk,
    output logic                   regHazard,
    output hazardPkg::fwdVec_t     fwd
);
    import hazardPkg::*;

    opcode_t op;
    regIdx_t rs;
    regIdx_t rt;
    logic    jumpReg;
    logic    idHitRs;
    logic    idHitRt;
    logic    exHitRs;
    logic    exHitRt;
    logic    memHitRs;
    logic    memHitRt;
    logic    wbHitRs;
    logic    wbHitRt;

    function automatic logic regHit(input regEntry_t e, input regIdx_t r);
        return e.valid && (e.dest == r);
    endfunction

    assign op      = opcodeOf(instr);
    assign rs      = rsOf(instr);
    assign rt      = rtOf(instr);
    assign jumpReg = (op == OP_JR) || (op == OP_JALR); // Target read in decode

    assign idHitRs  = regHit(regTrk.idEntry, rs);
    assign idHitRt  = regHit(regTrk.idEntry, rt);
    assign exHitRs  = regHit(regTrk.exEntry, rs);
    assign exHitRt  = regHit(regTrk.exEntry, rt);
    assign memHitRs = regHit(regTrk.memEntry, rs);
    assign memHitRt = regHit(regTrk.memEntry, rt);
    assign wbHitRs  = regHit(regTrk.wbEntry, rs);
    assign wbHitRt  = regHit(regTrk.wbEntry, rt);

    // ID entry is about to be squashed when the branch is taken
    assign regHazard = (op != OP_NOP) &&
                       (((idHitRs || idHitRt) && !branchTaken) ||
                        exHitRs || exHitRt ||
                        memHitRs || memHitRt ||
                        wbHitRs || wbHitRt);

    assign fwd.exToExRs  = idHitRs && !branchTaken;
    assign fwd.exToExRt  = idHitRt && !branchTaken;
    // Youngest producer wins, so ID match blocks the MEM path
    assign fwd.memToExRs = exHitRs && !idHitRs && !branchTaken;
    assign fwd.memToExRt = exHitRt && !idHitRt && !branchTaken;
    assign fwd.exToIdRs  = jumpReg && exHitRs && !memTrk.exEntry.en; // Load data not ready yet
    assign fwd.memToIdRs = jumpReg && memHitRs;

endmodule

/* hw/memHazardCheck.sv */
`timescale 1ns/1ps
`include "hazard_settings.svh"

module memHazardCheck (
    input  logic [`HAZ_DATA_W-1:0] imm,
    input  logic [`HAZ_DATA_W-1:0] reg1Data,
    input  logic                   memEnable,
    input  logic                   branchTaken,
    stageTrackIf.observe           memTrk,
    output logic [`HAZ_DATA_W-1:0] addr,
    output logic                   memHazard
);
    import hazardPkg::*;

    logic idHit;
    logic exHit;
    logic memHit;
    logic wbHit;

    // Enable and address are compared as a pair per stage
    function automatic logic addrHit(input memEntry_t e,
                                     input logic [`HAZ_DATA_W-1:0] a);
        return e.en && (e.addr == a);
    endfunction

    assign addr = reg1Data + imm; // Carry out dropped, sum wraps

    assign idHit  = addrHit(memTrk.idEntry, addr) && !branchTaken;
    assign exHit  = addrHit(memTrk.exEntry, addr);
    assign memHit = addrHit(memTrk.memEntry, addr);
    assign wbHit  = addrHit(memTrk.wbEntry, addr);

    assign memHazard = memEnable && (idHit || exHit || memHit || wbHit);

    // No access this cycle means nothing to conflict with
    memNeedsEnable: assert property (
        @(posedge memTrk.clk) memHazard |-> memEnable
    ) else $error("memHazardCheck: conflict flagged without an access");

endmodule

/* hw/hazardControl.sv */
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardControl (
    input  logic [`HAZ_DATA_W-1:0] instr,
    input  hazardPkg::regIdx_t     rd,
    input  logic                   writeValid,
    input  logic                   memEnable,
    input  logic                   branchTaken,
    input  logic [`HAZ_DATA_W-1:0] addr,
    input  logic                   regHazard,
    input  logic                   memHazard,
    stageTrackIf.ctrl              regTrk,
    stageTrackIf.ctrl              memTrk,
    output logic                   nop,
    output logic                   pcStall
);
    import hazardPkg::*;

    opcode_t   op;
    logic      link;
    logic      isNop;
    logic      hazard;
    regIdx_t   trueRd;
    regEntry_t regPush;
    memEntry_t memPush;

    assign op     = opcodeOf(instr);
    assign link   = (op == OP_JAL) || (op == OP_JALR); // 0011x
    assign isNop  = (op == OP_NOP);
    assign hazard = regHazard || memHazard;
    assign trueRd = link ? regIdx_t'(`HAZ_LINK_REG) : rd;

    // A stalled instruction is replayed later, so it is not tracked now
    always_comb begin
        regPush = '0;
        memPush = '0;
        if (!isNop && !hazard) begin
            regPush.dest  = trueRd;
            regPush.valid = writeValid;
            memPush.addr  = addr;
            memPush.en    = memEnable;
        end
    end

    assign regTrk.push  = regPush;
    assign memTrk.push  = memPush;
    assign regTrk.flush = branchTaken;
    assign memTrk.flush = branchTaken;

    assign pcStall = hazard && !branchTaken; // Redirect overrides the stall
    assign nop     = hazard || branchTaken;

    // Holding the PC without a bubble would issue the instruction twice
    stallHasBubble: assert property (
        @(posedge regTrk.clk) pcStall |-> nop
    ) else $error("hazardControl: PC stalled without a bubble");

endmodule

/* hw/hazardUnit.sv */
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardUnit (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`HAZ_DATA_W-1:0] instr,
    input  logic [`HAZ_DATA_W-1:0] imm,
    input  logic [`HAZ_DATA_W-1:0] reg1Data,
    input  hazardPkg::regIdx_t     rd,
    input  logic                   writeValid,
    input  logic                   memEnable,
    input  logic                   branchTaken,
    output logic                   nop,
    output logic                   pcStall,
    output logic [5:0]             forwards
);
    import hazardPkg::*;

    logic                   regHazard;
    logic                   memHazard;
    logic [`HAZ_DATA_W-1:0] addr;      // Reg1Data plus Imm of the decoding access
    fwdVec_t                fwd;

    stageTrackIf #(.T(regEntry_t)) regTrk (.clk(clk));
    stageTrackIf #(.T(memEntry_t)) memTrk (.clk(clk));

    // Destination registers in flight
    stagePipe #(.T(regEntry_t)) uRegPipe (
        .clk   (clk),
        .arstN (arstN),
        .trk   (regTrk.pipe)
    );

    // Memory accesses in flight
    stagePipe #(.T(memEntry_t)) uMemPipe (
        .clk   (clk),
        .arstN (arstN),
        .trk   (memTrk.pipe)
    );

    regHazardCheck uRegCheck (
        .instr       (instr),
        .branchTaken (branchTaken),
        .regTrk      (regTrk.observe),
        .memTrk      (memTrk.observe),
        .regHazard   (regHazard),
        .fwd         (fwd)
    );

    memHazardCheck uMemCheck (
        .imm         (imm),
        .reg1Data    (reg1Data),
        .memEnable   (memEnable),
        .branchTaken (branchTaken),
        .memTrk      (memTrk.observe),
        .addr        (addr),
        .memHazard   (memHazard)
    );

    hazardControl uControl (
        .instr       (instr),
        .rd          (rd),
        .writeValid  (writeValid),
        .memEnable   (memEnable),
        .branchTaken (branchTaken),
        .addr        (addr),
        .regHazard   (regHazard),
        .memHazard   (memHazard),
        .regTrk      (regTrk.ctrl),
        .memTrk      (memTrk.ctrl),
        .nop         (nop),
        .pcStall     (pcStall)
    );

    assign forwards = fwd; // exToExRs lands on bit 5

endmodule

/* tests/hazardUnit_tb.sv */
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardUnit_tb;
    import hazardPkg::*;

    localparam int clkPeriod    = 10;
    localparam int resetCycles  = 10;
    localparam int marginCycles = `HAZ_DEPTH + 20; // Slack on top of the case count

    // One line of the case file
    typedef struct packed {
        logic [`HAZ_DATA_W-1:0] instr;
        logic [`HAZ_DATA_W-1:0] imm;
        logic [`HAZ_DATA_W-1:0] reg1Data;
        regIdx_t                rd;
        logic                   writeValid;
        logic                   memEnable;
        logic                   branchTaken;
        logic                   expNop;
        logic                   expStall;
        fwdVec_t                expFwd;
    } caseRec_t;

    logic                   clk         = 1'b0;
    logic                   arstN       = 1'b0;
    logic [`HAZ_DATA_W-1:0] instr       = '0;
    logic [`HAZ_DATA_W-1:0] imm         = '0;
    logic [`HAZ_DATA_W-1:0] reg1Data    = '0;
    regIdx_t                rd          = '0;
    logic                   writeValid  = 1'b0;
    logic                   memEnable   = 1'b0;
    logic                   branchTaken = 1'b0;
    logic                   nop;
    logic                   pcStall;
    logic [5:0]             forwards;

    caseRec_t caseList[$];
    logic     loaded  = 1'b0;
    int       curCase = -1;  // Index of the line under check

    always #(clkPeriod / 2) clk = ~clk;

    hazardUnit DUT (
        .clk         (clk),
        .arstN       (arstN),
        .instr       (instr),
        .imm         (imm),
        .reg1Data    (reg1Data),
        .rd          (rd),
        .writeValid  (writeValid),
        .memEnable   (memEnable),
        .branchTaken (branchTaken),
        .nop         (nop),
        .pcStall     (pcStall),
        .forwards    (forwards)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "hazardUnit_tb stopped");
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail at %0t: %s got %b, expected %b (case %0d)",
                               $time, name, got, exp, curCase));
        end
    endtask

    task automatic checkFwd(input fwdVec_t got, input fwdVec_t exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail at %0t: forwards got %b, expected %b (case %0d)",
                               $time, got, exp, curCase));
        end
    endtask

    // Comment and blank lines are skipped, every other line needs ten fields
    task automatic loadCases();
        int                     fd;
        int                     n;
        string                  line;
        logic [`HAZ_DATA_W-1:0] fInstr;
        logic [`HAZ_DATA_W-1:0] fImm;
        logic [`HAZ_DATA_W-1:0] fReg1;
        logic [3:0]             fRd;
        logic                   fWv;
        logic                   fMe;
        logic                   fBt;
        logic                   fNop;
        logic                   fStall;
        logic [7:0]             fFwd;
        caseRec_t               rec;
        fd = $fopen("tests/hazard_cases.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the case file tests/hazard_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() >= 2 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", fInstr, fImm,
                                fReg1, fRd, fWv, fMe, fBt, fNop, fStall, fFwd);
                    if (n != 10) begin
                        abortRun($sformatf("Case file line is malformed: %s", line));
                    end
                    rec = '{fInstr, fImm, fReg1, fRd[2:0], fWv, fMe, fBt,
                            fNop, fStall, fwdVec_t'(fFwd[5:0])};
                    caseList.push_back(rec);
                end
            end
            $fclose(fd);
            if (caseList.size() == 0) begin
                abortRun("The case file holds no cases");
            end
            loaded = 1'b1;
        end
    endtask

    initial begin
        loadCases();
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        foreach (caseList[i]) begin
            @(posedge clk);
            instr       <= caseList[i].instr;
            imm         <= caseList[i].imm;
            reg1Data    <= caseList[i].reg1Data;
            rd          <= caseList[i].rd;
            writeValid  <= caseList[i].writeValid;
            memEnable   <= caseList[i].memEnable;
            branchTaken <= caseList[i].branchTaken;
            @(negedge clk); // Combinational outputs settled mid-cycle
            curCase = i;
            checkBit("nop", nop, caseList[i].expNop);
            checkBit("pcStall", pcStall, caseList[i].expStall);
            checkFwd(fwdVec_t'(forwards), caseList[i].expFwd);
        end
        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        #((caseList.size() + resetCycles + marginCycles) * clkPeriod);
        abortRun("Timeout: the cases did not finish in the expected time");
    end

endmodule

/* tests/hazard_cases.txt */
// instr imm reg1Data rd writeValid memEnable branchTaken expNop expPcStall expForwards
// All hex, one line per clock, forwards bit 5 is exToExRs down to bit 0 memToIdRs
// Idle after reset, then a taken branch alone
0000 0000 0000 0 0 0 0 0 0 00
0000 0000 0000 0 0 0 1 1 0 00
0000 0000 0000 0 0 0 0 0 0 00
// r3 written, then read as rs and rt through every stage
1140 0000 0000 3 1 0 0 0 0 00
1300 0000 0000 0 0 0 0 1 1 20
1060 0000 0000 0 0 0 0 1 1 04
1300 0000 0000 0 0 0 0 1 1 00
1060 0000 0000 0 0 0 0 1 1 00
1300 0000 0000 0 0 0 0 0 0 00
// NOP naming r3 never stalls
1140 0000 0000 3 1 0 0 0 0 00
0b60 0000 0000 0 0 0 0 0 0 28
0b60 0000 0000 0 0 0 0 0 0 14
0000 0000 0000 0 0 0 0 0 0 00
0000 0000 0000 0 0 0 0 0 0 00
// Two writers of r4, ID priority, then JR and JALR bypass
1140 0000 0000 4 1 0 0 0 0 00
1140 0000 0000 4 1 0 0 0 0 00
1480 0000 0000 0 0 0 0 1 1 28
2c00 0000 0000 0 0 0 0 1 1 13
3c00 0000 0000 0 1 0 0 1 1 01
1700 0000 0000 0 0 0 0 0 0 00
// Load into r5 blocks the EX to ID path
1140 0010 0100 5 1 1 0 0 0 00
0000 0000 0000 0 0 0 0 0 0 00
2d00 0000 0000 0 0 0 0 1 1 10
2d00 0000 0000 0 0 0 0 1 1 01
0000 0000 0000 0 0 0 0 0 0 00
// Taken branch squashes the r6 writer in ID
1140 0000 0000 6 1 0 0 0 0 00
1600 0000 0000 0 0 0 1 1 0 00
1600 0000 0000 0 0 0 0 0 0 00
10c0 0000 0000 0 0 0 0 0 0 00
1600 0000 0000 0 0 0 0 0 0 00
// Redirect wins over a real hazard
1100 0000 0000 2 1 0 0 0 0 00
0000 0000 0000 0 0 0 0 0 0 00
1200 0000 0000 0 0 0 1 1 0 00
0000 0000 0000 0 0 0 0 0 0 00
0000 0000 0000 0 0 0 0 0 0 00
// Memory conflicts on Reg1Data plus Imm, one sum wraps
0000 0234 1000 0 0 1 0 0 0 00
0000 1235 ffff 0 0 1 0 1 1 00
0000 0235 1000 0 0 1 0 0 0 00
0000 0000 2000 0 0 0 0 0 0 00
0000 0000 2000 0 0 1 0 0 0 00
0000 0000 1235 0 0 1 0 1 1 00
0000 0000 2000 0 0 0 0 0 0 00
0000 0000 0000 0 0 0 0 0 0 00
// Accesses caught by taken branches are forgotten
0000 0000 0400 0 0 1 0 0 0 00
0000 0000 0400 0 0 1 1 1 0 00
0000 0000 0500 0 0 1 1 1 0 00
0000 0000 0000 0 0 0 0 0 0 00
0000 0000 0400 0 0 1 0 0 0 00
// JAL writes r7 whatever rd says
3000 0000 0000 2 1 0 0 0 0 00
1740 0000 0000 0 0 0 0 1 1 20
1040 0000 0000 0 0 0 0 0 0 00
// Stalled reader of r5 is not tracked while it waits
1140 0000 0000 5 1 0 0 0 0 00
1500 0000 0000 5 1 0 0 1 1 20
1500 0000 0000 5 1 0 0 1 1 10
1500 0000 0000 5 1 0 0 1 1 00
1500 0000 0000 5 1 0 0 1 1 00
1500 0000 0000 5 1 0 0 0 0 00
0000 0000 0000 0 0 0 0 0 0 00

/* build.f */
+incdir+include
hw/hazardPkg.sv
hw/stageTrackIf.sv
hw/stagePipe.sv
hw/regHazardCheck.sv
hw/memHazardCheck.sv
hw/hazardControl.sv
hw/hazardUnit.sv
tests/hazardUnit_tb.sv

/* Makefile */
# Verilator simulation of the hazard unit

TOP := hazardUnit_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the cases and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir -o Vsim
	./obj_dir/Vsim | tee $(LOG)
	@grep -q "^RESULT: PASS" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
